// File: hw/axi_sram_pkg.sv
// Shared AXI codes and beat address stepping for byte addresses of at most 64 bits
package axi_sram_pkg;

  // -------------------------------------------------------------------------
  // Channel encodings
  // -------------------------------------------------------------------------
  localparam logic [1:0] BURST_FIXED = 2'b00;
  localparam logic [1:0] BURST_INCR  = 2'b01;
  localparam logic [1:0] BURST_WRAP  = 2'b10;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  localparam int MAX_LEN_W   = 8;
  localparam int CALC_ADDR_W = 64;

  // -------------------------------------------------------------------------
  // Beat address stepping
  // -------------------------------------------------------------------------
  function automatic logic [CALC_ADDR_W-1:0] next_beat_addr(
    input logic [CALC_ADDR_W-1:0] addr,
    input logic [2:0]             size,
    input logic [MAX_LEN_W-1:0]   len,
    input logic [1:0]             burst
  );
    logic [CALC_ADDR_W-1:0] beat_bytes;
    logic [CALC_ADDR_W-1:0] stepped;
    logic [CALC_ADDR_W-1:0] wrap_mask;
    logic [CALC_ADDR_W-1:0] result;
    beat_bytes = CALC_ADDR_W'(1) << size;
    stepped    = (addr & ~(beat_bytes - 1'b1)) + beat_bytes;
    // Block of len+1 beats, a power of two for legal WRAP lengths
    wrap_mask  = ((CALC_ADDR_W'(len) + 1'b1) << size) - 1'b1;
    case (burst)
      BURST_FIXED: result = addr;
      BURST_INCR:  result = stepped;
      BURST_WRAP:  result = (addr & ~wrap_mask) | (stepped & wrap_mask);
      // Reserved code steps like INCR
      default:     result = stepped;
    endcase
    return result;
  endfunction

endpackage

// File: hw/axi_burst_addr.sv
// Next beat address of an AXI burst for byte addresses no wider than 64 bits
module axi_burst_addr #(
  parameter int ADDR_WIDTH = 32
) (
  input  logic [ADDR_WIDTH-1:0]              i_addr,
  input  logic [2:0]                         i_size,
  input  logic [axi_sram_pkg::MAX_LEN_W-1:0] i_len,
  input  logic [1:0]                         i_burst,
  output logic [ADDR_WIDTH-1:0]              o_next_addr
);

  localparam int CALC_W = axi_sram_pkg::CALC_ADDR_W;

  logic [CALC_W-1:0] addr_ext;
  logic [CALC_W-1:0] next_ext;

  // Zero extend into the calculation width
  always_comb begin
    addr_ext                 = '0;
    addr_ext[ADDR_WIDTH-1:0] = i_addr;
  end

  always_comb begin
    next_ext = axi_sram_pkg::next_beat_addr(addr_ext, i_size, i_len, i_burst);
  end

  // Upper bits beyond the bus address are dropped, so INCR rolls over
  assign o_next_addr = next_ext[ADDR_WIDTH-1:0];

endmodule

// File: hw/sram_mem.sv
// Word memory without reset whose read of a word being written returns the old data
module sram_mem #(
  parameter int  DATA_WIDTH = 64,
  parameter int  MEM_DEPTH  = 1024,
  localparam int STRB_WIDTH = DATA_WIDTH / 8,
  localparam int WORD_AW    = $clog2(MEM_DEPTH)
) (
  input  logic                  i_aclk,
  input  logic                  i_rd_en,
  input  logic [WORD_AW-1:0]    i_rd_addr,
  input  logic                  i_wr_en,
  input  logic [WORD_AW-1:0]    i_wr_addr,
  input  logic [DATA_WIDTH-1:0] i_wr_data,
  input  logic [STRB_WIDTH-1:0] i_wr_strb,
  output logic [DATA_WIDTH-1:0] o_rd_data
);

  logic [DATA_WIDTH-1:0] mem_q [MEM_DEPTH];

  // Read port, output register holds while not enabled
  always_ff @(posedge i_aclk) begin
    if (i_rd_en) begin
      o_rd_data <= mem_q[i_rd_addr];
    end
  end

  // Write port with byte lanes
  always_ff @(posedge i_aclk) begin
    if (i_wr_en) begin
      for (int b = 0; b < STRB_WIDTH; b++) begin
        if (i_wr_strb[b]) begin
          mem_q[i_wr_addr][8*b +: 8] <= i_wr_data[8*b +: 8];
        end
      end
    end
  end

endmodule

// File: hw/axi_sram_rd.sv
// Read channel engine with one burst in flight, fed by a memory with one cycle of read latency
module axi_sram_rd #(
  parameter int  DATA_WIDTH = 64,
  parameter int  ADDR_WIDTH = 32,
  parameter int  ID_WIDTH   = 4,
  parameter int  MEM_DEPTH  = 1024,
  localparam int WORD_AW    = $clog2(MEM_DEPTH)
) (
  input  logic                               i_aclk,
  input  logic                               i_arst_n,
  input  logic [ID_WIDTH-1:0]                i_arid,
  input  logic [ADDR_WIDTH-1:0]              i_araddr,
  input  logic [axi_sram_pkg::MAX_LEN_W-1:0] i_arlen,
  input  logic [2:0]                         i_arsize,
  input  logic [1:0]                         i_arburst,
  input  logic                               i_arvalid,
  output logic                               o_arready,
  output logic [ID_WIDTH-1:0]                o_rid,
  output logic [DATA_WIDTH-1:0]              o_rdata,
  output logic [1:0]                         o_rresp,
  output logic                               o_rlast,
  output logic                               o_rvalid,
  input  logic                               i_rready,
  output logic                               o_rd_en,
  output logic [WORD_AW-1:0]                 o_rd_addr,
  input  logic [DATA_WIDTH-1:0]              i_rd_data
);

  localparam int STRB_WIDTH = DATA_WIDTH / 8;
  localparam int OFFS_W     = $clog2(STRB_WIDTH);
  localparam int IDX_W      = ADDR_WIDTH - OFFS_W;
  localparam int LEN_W      = axi_sram_pkg::MAX_LEN_W;

  localparam logic [IDX_W-1:0] WORD_LIMIT = IDX_W'(MEM_DEPTH);

  localparam logic ST_IDLE   = 1'b0;
  localparam logic ST_STREAM = 1'b1;

  logic                  state_q;
  logic [ID_WIDTH-1:0]   id_q;
  logic [ADDR_WIDTH-1:0] addr_q;
  logic [LEN_W-1:0]      len_q;
  logic [2:0]            size_q;
  logic [1:0]            burst_q;
  logic [LEN_W-1:0]      beat_q;
  logic                  err_q;

  logic                  ar_fire;
  logic                  r_fire;
  logic                  req_go;
  logic [ADDR_WIDTH-1:0] next_addr;
  logic [ADDR_WIDTH-1:0] req_addr;
  logic [IDX_W-1:0]      req_idx;
  logic                  req_oor;

  assign o_arready = (state_q == ST_IDLE);
  assign o_rvalid  = (state_q == ST_STREAM);
  assign ar_fire   = i_arvalid & o_arready;
  assign r_fire    = o_rvalid & i_rready;
  assign o_rlast   = o_rvalid & (beat_q == len_q);

  axi_burst_addr #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_addr (
    .i_addr      (addr_q),
    .i_size      (size_q),
    .i_len       (len_q),
    .i_burst     (burst_q),
    .o_next_addr (next_addr)
  );

  // -------------------------------------------------------------------------
  // Memory request, one beat ahead of the R channel
  // -------------------------------------------------------------------------
  assign req_go    = ar_fire | (r_fire & ~o_rlast);
  assign req_addr  = ar_fire ? i_araddr : next_addr;
  assign req_idx   = req_addr[ADDR_WIDTH-1:OFFS_W];
  assign req_oor   = (req_idx >= WORD_LIMIT);
  assign o_rd_en   = req_go & ~req_oor;
  assign o_rd_addr = req_idx[WORD_AW-1:0];

  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q <= ST_IDLE;
      beat_q  <= '0;
      err_q   <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: if (ar_fire) state_q <= ST_STREAM;
        default: if (r_fire && o_rlast) state_q <= ST_IDLE;
      endcase
      if (ar_fire) begin
        beat_q <= '0;
      end else if (r_fire) begin
        beat_q <= beat_q + 1'b1;
      end
      // Error flag follows the beat whose word was requested
      if (req_go) begin
        err_q <= req_oor;
      end
    end
  end

  always_ff @(posedge i_aclk) begin
    if (ar_fire) begin
      id_q    <= i_arid;
      len_q   <= i_arlen;
      size_q  <= i_arsize;
      burst_q <= i_arburst;
    end
    if (req_go) begin
      addr_q <= req_addr;
    end
  end

  assign o_rid   = id_q;
  assign o_rresp = err_q ? axi_sram_pkg::RESP_SLVERR : axi_sram_pkg::RESP_OKAY;
  assign o_rdata = err_q ? '0 : i_rd_data;

endmodule

// File: hw/axi_sram_wr.sv
// Write channel engine taking W beats only after their AW with one burst in flight
module axi_sram_wr #(
  parameter int  DATA_WIDTH = 64,
  parameter int  ADDR_WIDTH = 32,
  parameter int  ID_WIDTH   = 4,
  parameter int  MEM_DEPTH  = 1024,
  localparam int STRB_WIDTH = DATA_WIDTH / 8,
  localparam int WORD_AW    = $clog2(MEM_DEPTH)
) (
  input  logic                               i_aclk,
  input  logic                               i_arst_n,
  input  logic [ID_WIDTH-1:0]                i_awid,
  input  logic [ADDR_WIDTH-1:0]              i_awaddr,
  input  logic [axi_sram_pkg::MAX_LEN_W-1:0] i_awlen,
  input  logic [2:0]                         i_awsize,
  input  logic [1:0]                         i_awburst,
  input  logic                               i_awvalid,
  output logic                               o_awready,
  input  logic [DATA_WIDTH-1:0]              i_wdata,
  input  logic [STRB_WIDTH-1:0]              i_wstrb,
  input  logic                               i_wlast,
  input  logic                               i_wvalid,
  output logic                               o_wready,
  output logic [ID_WIDTH-1:0]                o_bid,
  output logic [1:0]                         o_bresp,
  output logic                               o_bvalid,
  input  logic                               i_bready,
  output logic                               o_wr_en,
  output logic [WORD_AW-1:0]                 o_wr_addr,
  output logic [DATA_WIDTH-1:0]              o_wr_data,
  output logic [STRB_WIDTH-1:0]              o_wr_strb
);

  localparam int OFFS_W = $clog2(STRB_WIDTH);
  localparam int IDX_W  = ADDR_WIDTH - OFFS_W;
  localparam int LEN_W  = axi_sram_pkg::MAX_LEN_W;

  localparam logic [IDX_W-1:0] WORD_LIMIT = IDX_W'(MEM_DEPTH);

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_DATA = 2'd1;
  localparam logic [1:0] ST_RESP = 2'd2;

  logic [1:0]            state_q;
  logic [ID_WIDTH-1:0]   id_q;
  logic [ADDR_WIDTH-1:0] addr_q;
  logic [LEN_W-1:0]      len_q;
  logic [2:0]            size_q;
  logic [1:0]            burst_q;
  logic                  err_q;

  logic                  aw_fire;
  logic                  w_fire;
  logic                  b_fire;
  logic [ADDR_WIDTH-1:0] next_addr;
  logic [IDX_W-1:0]      cur_idx;
  logic                  cur_oor;

  assign o_awready = (state_q == ST_IDLE);
  assign o_wready  = (state_q == ST_DATA);
  assign o_bvalid  = (state_q == ST_RESP);
  assign aw_fire   = i_awvalid & o_awready;
  assign w_fire    = i_wvalid & o_wready;
  assign b_fire    = o_bvalid & i_bready;

  axi_burst_addr #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) u_addr (
    .i_addr      (addr_q),
    .i_size      (size_q),
    .i_len       (len_q),
    .i_burst     (burst_q),
    .o_next_addr (next_addr)
  );

  // -------------------------------------------------------------------------
  // Memory write port
  // -------------------------------------------------------------------------
  assign cur_idx   = addr_q[ADDR_WIDTH-1:OFFS_W];
  assign cur_oor   = (cur_idx >= WORD_LIMIT);
  assign o_wr_en   = w_fire & ~cur_oor;
  assign o_wr_addr = cur_idx[WORD_AW-1:0];
  assign o_wr_data = i_wdata;
  assign o_wr_strb = i_wstrb;

  always_ff @(posedge i_aclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q <= ST_IDLE;
      err_q   <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: if (aw_fire) state_q <= ST_DATA;
        ST_DATA: if (w_fire && i_wlast) state_q <= ST_RESP;
        ST_RESP: if (b_fire) state_q <= ST_IDLE;
        default: state_q <= ST_IDLE;
      endcase
      // Sticky over the whole burst
      if (aw_fire) begin
        err_q <= 1'b0;
      end else if (w_fire && cur_oor) begin
        err_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge i_aclk) begin
    if (aw_fire) begin
      id_q    <= i_awid;
      addr_q  <= i_awaddr;
      len_q   <= i_awlen;
      size_q  <= i_awsize;
      burst_q <= i_awburst;
    end else if (w_fire) begin
      addr_q <= next_addr;
    end
  end

  assign o_bid   = id_q;
  assign o_bresp = err_q ? axi_sram_pkg::RESP_SLVERR : axi_sram_pkg::RESP_OKAY;

endmodule

// File: hw/axi_sram_top.sv
// AXI4 slave over on-chip SRAM with one burst in flight per direction and no lock, cache or prot
module axi_sram_top #(
  parameter int  DATA_WIDTH = 64,
  parameter int  ADDR_WIDTH = 32,
  parameter int  ID_WIDTH   = 4,
  parameter int  MEM_DEPTH  = 1024,
  localparam int STRB_WIDTH = DATA_WIDTH / 8,
  localparam int WORD_AW    = $clog2(MEM_DEPTH)
) (
  input  logic                               i_aclk,
  input  logic                               i_arst_n,
  // Write address
  input  logic [ID_WIDTH-1:0]                i_awid,
  input  logic [ADDR_WIDTH-1:0]              i_awaddr,
  input  logic [axi_sram_pkg::MAX_LEN_W-1:0] i_awlen,
  input  logic [2:0]                         i_awsize,
  input  logic [1:0]                         i_awburst,
  input  logic                               i_awvalid,
  output logic                               o_awready,
  // Write data
  input  logic [DATA_WIDTH-1:0]              i_wdata,
  input  logic [STRB_WIDTH-1:0]              i_wstrb,
  input  logic                               i_wlast,
  input  logic                               i_wvalid,
  output logic                               o_wready,
  // Write response
  output logic [ID_WIDTH-1:0]                o_bid,
  output logic [1:0]                         o_bresp,
  output logic                               o_bvalid,
  input  logic                               i_bready,
  // Read address
  input  logic [ID_WIDTH-1:0]                i_arid,
  input  logic [ADDR_WIDTH-1:0]              i_araddr,
  input  logic [axi_sram_pkg::MAX_LEN_W-1:0] i_arlen,
  input  logic [2:0]                         i_arsize,
  input  logic [1:0]                         i_arburst,
  input  logic                               i_arvalid,
  output logic                               o_arready,
  // Read data
  output logic [ID_WIDTH-1:0]                o_rid,
  output logic [DATA_WIDTH-1:0]              o_rdata,
  output logic [1:0]                         o_rresp,
  output logic                               o_rlast,
  output logic                               o_rvalid,
  input  logic                               i_rready
);

  logic                  rd_en;
  logic [WORD_AW-1:0]    rd_addr;
  logic [DATA_WIDTH-1:0] rd_data;
  logic                  wr_en;
  logic [WORD_AW-1:0]    wr_addr;
  logic [DATA_WIDTH-1:0] wr_data;
  logic [STRB_WIDTH-1:0] wr_strb;

  // -------------------------------------------------------------------------
  // Read and write engines
  // -------------------------------------------------------------------------
  axi_sram_rd #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH),
    .ID_WIDTH   (ID_WIDTH),
    .MEM_DEPTH  (MEM_DEPTH)
  ) u_rd (
    .i_aclk    (i_aclk),
    .i_arst_n  (i_arst_n),
    .i_arid    (i_arid),
    .i_araddr  (i_araddr),
    .i_arlen   (i_arlen),
    .i_arsize  (i_arsize),
    .i_arburst (i_arburst),
    .i_arvalid (i_arvalid),
    .o_arready (o_arready),
    .o_rid     (o_rid),
    .o_rdata   (o_rdata),
    .o_rresp   (o_rresp),
    .o_rlast   (o_rlast),
    .o_rvalid  (o_rvalid),
    .i_rready  (i_rready),
    .o_rd_en   (rd_en),
    .o_rd_addr (rd_addr),
    .i_rd_data (rd_data)
  );

  axi_sram_wr #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH),
    .ID_WIDTH   (ID_WIDTH),
    .MEM_DEPTH  (MEM_DEPTH)
  ) u_wr (
    .i_aclk    (i_aclk),
    .i_arst_n  (i_arst_n),
    .i_awid    (i_awid),
    .i_awaddr  (i_awaddr),
    .i_awlen   (i_awlen),
    .i_awsize  (i_awsize),
    .i_awburst (i_awburst),
    .i_awvalid (i_awvalid),
    .o_awready (o_awready),
    .i_wdata   (i_wdata),
    .i_wstrb   (i_wstrb),
    .i_wlast   (i_wlast),
    .i_wvalid  (i_wvalid),
    .o_wready  (o_wready),
    .o_bid     (o_bid),
    .o_bresp   (o_bresp),
    .o_bvalid  (o_bvalid),
    .i_bready  (i_bready),
    .o_wr_en   (wr_en),
    .o_wr_addr (wr_addr),
    .o_wr_data (wr_data),
    .o_wr_strb (wr_strb)
  );

  sram_mem #(
    .DATA_WIDTH (DATA_WIDTH),
    .MEM_DEPTH  (MEM_DEPTH)
  ) u_mem (
    .i_aclk    (i_aclk),
    .i_rd_en   (rd_en),
    .i_rd_addr (rd_addr),
    .i_wr_en   (wr_en),
    .i_wr_addr (wr_addr),
    .i_wr_data (wr_data),
    .i_wr_strb (wr_strb),
    .o_rd_data (rd_data)
  );

endmodule

// File: sim/tb_axi_sram.sv
// Runs the DUT with a 64-bit bus and 1024 words, and fills every word through AXI before any read
module tb_axi_sram;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int DW     = 64;
  localparam int AW     = 32;
  localparam int IW     = 4;
  localparam int DEPTH  = 1024;
  localparam int NBYTES = DEPTH * 8;
  // Beats of fill, single, random INCR, WRAP and FIXED, narrow, range, backpressure
  localparam int TOTAL_BEATS = 1024 + 2 + 640 + 41 + 62 + 23 + 160;
  localparam int CYCLE_LIMIT = 20 * TOTAL_BEATS + 500;

  logic          aclk;
  logic          arst_n;
  logic [IW-1:0] awid, arid, bid, rid;
  logic [AW-1:0] awaddr, araddr;
  logic [7:0]    awlen, arlen, wstrb;
  logic [2:0]    awsize, arsize;
  logic [1:0]    awburst, arburst, bresp, rresp;
  logic [DW-1:0] wdata, rdata;
  logic          awvalid, awready, wlast, wvalid, wready, bvalid, bready;
  logic          arvalid, arready, rlast, rvalid, rready;

  logic [7:0]     ref_mem [NBYTES];
  logic [IW+66:0] exp_r [$];
  logic [IW+1:0]  exp_b [$];
  logic [DW-1:0]  wbuf [256];
  logic [7:0]     sbuf [256];
  string          test_name = "reset";
  int             test_errs = 0;
  int             err_total = 0;
  int             tests_run = 0;
  int             tests_failed = 0;
  int             cycles = 0;
  logic           stall_en = 1'b0;
  logic           r_held = 1'b0;
  logic           b_held = 1'b0;
  logic [IW+66:0] r_prev;

  axi_sram_top #(
    .DATA_WIDTH (DW),
    .ADDR_WIDTH (AW),
    .ID_WIDTH   (IW),
    .MEM_DEPTH  (DEPTH)
  ) u_axi_sram_top (
    .i_aclk    (aclk),
    .i_arst_n  (arst_n),
    .i_awid    (awid),
    .i_awaddr  (awaddr),
    .i_awlen   (awlen),
    .i_awsize  (awsize),
    .i_awburst (awburst),
    .i_awvalid (awvalid),
    .o_awready (awready),
    .i_wdata   (wdata),
    .i_wstrb   (wstrb),
    .i_wlast   (wlast),
    .i_wvalid  (wvalid),
    .o_wready  (wready),
    .o_bid     (bid),
    .o_bresp   (bresp),
    .o_bvalid  (bvalid),
    .i_bready  (bready),
    .i_arid    (arid),
    .i_araddr  (araddr),
    .i_arlen   (arlen),
    .i_arsize  (arsize),
    .i_arburst (arburst),
    .i_arvalid (arvalid),
    .o_arready (arready),
    .o_rid     (rid),
    .o_rdata   (rdata),
    .o_rresp   (rresp),
    .o_rlast   (rlast),
    .o_rvalid  (rvalid),
    .i_rready  (rready)
  );

  initial aclk = 1'b0;
  always #2 aclk = ~aclk;

  always @(posedge aclk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: the run hung after %0d cycles in test %s", cycles, test_name);
      $display("** FAIL **");
      $finish;
    end
  end

  // Random low cycles on the response ready signals
  always @(posedge aclk) begin
    #1;
    rready = stall_en ? ($urandom % 3 != 0) : 1'b1;
    bready = stall_en ? ($urandom % 3 != 0) : 1'b1;
  end

  // --------------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------------
  function automatic logic [AW-1:0] beat_addr(input logic [AW-1:0] start,
      input logic [2:0] size, input logic [7:0] len, input logic [1:0] burst, input int n);
    logic [AW-1:0] bytes;
    logic [AW-1:0] total;
    logic [AW-1:0] base;
    logic [AW-1:0] lower;
    bytes = AW'(1) << size;
    total = bytes * (len + 1);
    base  = start / bytes * bytes;
    lower = start / total * total;
    if (burst == axi_sram_pkg::BURST_FIXED || n == 0) return start;
    if (burst == axi_sram_pkg::BURST_WRAP) return lower + ((base - lower + n * bytes) % total);
    return base + n * bytes;
  endfunction

  function automatic logic [DW+1:0] ref_read_beat(input logic [AW-1:0] addr);
    logic [DW-1:0] d;
    if ((addr >> 3) >= DEPTH) return {axi_sram_pkg::RESP_SLVERR, {DW{1'b0}}};
    for (int b = 0; b < 8; b++) begin
      d[8*b +: 8] = ref_mem[{addr[AW-1:3], 3'b000} + b];
    end
    return {axi_sram_pkg::RESP_OKAY, d};
  endfunction

  task automatic report_mismatch(input logic [127:0] want, input logic [127:0] got);
    $display("ERR %s: expected %0h actual %0h", test_name, want, got);
    test_errs++;
    err_total++;
  endtask

  task automatic report_fault(input string msg);
    $display("Error in test %s: %s", test_name, msg);
    test_errs++;
    err_total++;
  endtask

  task automatic finish_test();
    tests_run++;
    if (test_errs != 0) tests_failed++;
    $display("test %-14s %s, %0d errors", test_name, (test_errs == 0) ? "ok" : "failed",
             test_errs);
    test_errs = 0;
  endtask

  // --------------------------------------------------------------------------
  // AXI master tasks, entered and left 1 ns after a rising edge
  // --------------------------------------------------------------------------
  task automatic write_burst(input logic [IW-1:0] id, input logic [AW-1:0] addr,
      input logic [7:0] len, input logic [2:0] size, input logic [1:0] burst);
    logic [AW-1:0] a;
    logic          err;
    err = 1'b0;
    for (int n = 0; n <= len; n++) begin
      a = beat_addr(addr, size, len, burst, n);
      if ((a >> 3) >= DEPTH) begin
        err = 1'b1;
      end else begin
        for (int b = 0; b < 8; b++) begin
          if (sbuf[n][b]) ref_mem[{a[AW-1:3], 3'b000} + b] = wbuf[n][8*b +: 8];
        end
      end
    end
    exp_b.push_back({id, err ? axi_sram_pkg::RESP_SLVERR : axi_sram_pkg::RESP_OKAY});
    awid    = id;
    awaddr  = addr;
    awlen   = len;
    awsize  = size;
    awburst = burst;
    awvalid = 1'b1;
    do @(negedge aclk); while (!awready);
    @(posedge aclk);
    #1 awvalid = 1'b0;
    for (int n = 0; n <= len; n++) begin
      wdata  = wbuf[n];
      wstrb  = sbuf[n];
      wlast  = (n == len);
      wvalid = 1'b1;
      do @(negedge aclk); while (!wready);
      @(posedge aclk);
      #1;
    end
    wvalid = 1'b0;
    wlast  = 1'b0;
    while (exp_b.size() != 0) @(negedge aclk);
    @(posedge aclk);
    #1;
  endtask

  task automatic read_burst(input logic [IW-1:0] id, input logic [AW-1:0] addr,
      input logic [7:0] len, input logic [2:0] size, input logic [1:0] burst);
    for (int n = 0; n <= len; n++) begin
      exp_r.push_back({id, n == len, ref_read_beat(beat_addr(addr, size, len, burst, n))});
    end
    arid    = id;
    araddr  = addr;
    arlen   = len;
    arsize  = size;
    arburst = burst;
    arvalid = 1'b1;
    do @(negedge aclk); while (!arready);
    @(posedge aclk);
    #1 arvalid = 1'b0;
    @(negedge aclk);
    if (!rvalid) report_fault("no R beat one cycle after the AR transfer");
    while (exp_r.size() != 0) @(negedge aclk);
    @(posedge aclk);
    #1;
  endtask

  // Compare process, sampled mid-cycle where every output is settled
  always @(negedge aclk) begin : compare
    logic [IW+66:0] got;
    logic [IW+66:0] want;
    logic [IW+1:0]  got_b;
    got   = {rid, rlast, rresp, rdata};
    got_b = {bid, bresp};
    if (r_held && (!rvalid || got !== r_prev)) report_fault("R channel changed while stalled");
    if (b_held && !bvalid) report_fault("B valid dropped before its handshake");
    r_held = rvalid && !rready;
    b_held = bvalid && !bready;
    r_prev = got;
    if (rvalid && rready) begin
      if (exp_r.size() == 0) begin
        report_fault("R beat with no read outstanding");
      end else begin
        want = exp_r.pop_front();
        if (got !== want) report_mismatch(want, got);
      end
    end
    if (bvalid && bready) begin
      if (exp_b.size() == 0) report_fault("B response with no write outstanding");
      else if (got_b !== exp_b[0]) report_mismatch(exp_b.pop_front(), got_b);
      else void'(exp_b.pop_front());
    end
  end

  // --------------------------------------------------------------------------
  // Tests
  // --------------------------------------------------------------------------
  initial begin
    logic [AW-1:0] a;
    logic [7:0]    len;
    void'($urandom(32'h9bd8));
    {arst_n, awvalid, wvalid, wlast, arvalid, rready, bready} = '0;
    {awid, awaddr, awlen, awsize, awburst, wdata, wstrb} = '0;
    {arid, araddr, arlen, arsize, arburst} = '0;
    repeat (8) @(posedge aclk);
    #1 arst_n = 1'b1;
    @(posedge aclk);
    #1;

    // Idle handshake levels: rvalid, bvalid, wready low, awready, arready high
    if ({rvalid, bvalid, wready, awready, arready} !== 5'b00011) begin
      report_mismatch(5'b00011, {rvalid, bvalid, wready, awready, arready});
    end
    finish_test();

    test_name = "fill";
    for (int blk = 0; blk < 4; blk++) begin
      for (int n = 0; n < 256; n++) begin
        a       = (blk * 256 + n) * 8;
        wbuf[n] = {a, a ^ 32'h5a5a_c3c3};
        sbuf[n] = 8'hff;
      end
      write_burst(4'(blk), blk * 2048, 255, 3, axi_sram_pkg::BURST_INCR);
    end
    finish_test();

    test_name = "single";
    wbuf[0] = 64'h0123_4567_89ab_cdef;
    sbuf[0] = 8'hff;
    write_burst(4'h1, 32'h40, 0, 3, axi_sram_pkg::BURST_INCR);
    read_burst(4'h2, 32'h40, 0, 3, axi_sram_pkg::BURST_INCR);
    finish_test();

    test_name = "incr_random";
    for (int t = 0; t < 20; t++) begin
      len = $urandom % 16;
      a   = ($urandom % (DEPTH - 16)) * 8;
      for (int n = 0; n <= len; n++) begin
        wbuf[n] = {$urandom, $urandom};
        sbuf[n] = 8'($urandom);
      end
      write_burst(4'($urandom), a, len, 3, axi_sram_pkg::BURST_INCR);
      read_burst(4'($urandom), a, len, 3, axi_sram_pkg::BURST_INCR);
    end
    finish_test();

    test_name = "wrap_fixed";
    for (int k = 0; k < 2; k++) begin
      len = (k == 0) ? 3 : 7;
      a   = 32'h200 + ((k == 0) ? 16 : 24);
      for (int n = 0; n <= len; n++) begin
        wbuf[n] = {$urandom, $urandom};
        sbuf[n] = 8'hff;
      end
      write_burst(4'h3, a, len, 3, axi_sram_pkg::BURST_WRAP);
      read_burst(4'h4, a, len, 3, axi_sram_pkg::BURST_WRAP);
      // Linear read of the block shows where each wrapped beat landed
      read_burst(4'h5, 32'h200, len, 3, axi_sram_pkg::BURST_INCR);
    end
    for (int n = 0; n < 4; n++) wbuf[n] = {$urandom, $urandom};
    sbuf[0] = 8'hff;
    sbuf[1] = 8'h0f;
    sbuf[2] = 8'hf0;
    sbuf[3] = 8'h3c;
    write_burst(4'h6, 32'h300, 3, 3, axi_sram_pkg::BURST_FIXED);
    read_burst(4'h7, 32'h300, 0, 3, axi_sram_pkg::BURST_FIXED);
    finish_test();

    test_name = "narrow";
    for (int s = 0; s < 3; s++) begin
      a = 32'h400 + s * 32'h80;
      for (int n = 0; n < 16; n++) begin
        wbuf[n] = {$urandom, $urandom};
        sbuf[n] = 8'(((1 << (1 << s)) - 1) << ((a + n * (1 << s)) % 8));
      end
      write_burst(4'h8, a, 15, 3'(s), axi_sram_pkg::BURST_INCR);
      read_burst(4'h9, a, 8'((2 << s) - 1), 3, axi_sram_pkg::BURST_INCR);
    end
    finish_test();

    test_name = "out_of_range";
    for (int n = 0; n < 8; n++) begin
      wbuf[n] = {$urandom, $urandom};
      sbuf[n] = 8'hff;
    end
    write_burst(4'ha, NBYTES - 24, 7, 3, axi_sram_pkg::BURST_INCR);
    read_burst(4'hb, NBYTES - 24, 7, 3, axi_sram_pkg::BURST_INCR);
    for (int n = 0; n < 4; n++) begin
      wbuf[n] = {$urandom, $urandom};
      sbuf[n] = n[0] ? 8'h0f : 8'hf0;
    end
    write_burst(4'hc, NBYTES - 4, 3, 2, axi_sram_pkg::BURST_INCR);
    read_burst(4'hd, NBYTES - 8, 2, 3, axi_sram_pkg::BURST_INCR);
    finish_test();

    test_name = "backpressure";
    stall_en  = 1'b1;
    for (int t = 0; t < 10; t++) begin
      len = $urandom % 8;
      a   = ($urandom % (DEPTH - 8)) * 8;
      for (int n = 0; n <= len; n++) begin
        wbuf[n] = {$urandom, $urandom};
        sbuf[n] = 8'($urandom);
      end
      write_burst(4'($urandom), a, len, 3, axi_sram_pkg::BURST_INCR);
      read_burst(4'($urandom), a, len, 3, axi_sram_pkg::BURST_INCR);
    end
    stall_en = 1'b0;
    finish_test();

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_total);
    if (err_total == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: list.f
hw/axi_sram_pkg.sv
hw/axi_burst_addr.sv
hw/sram_mem.sv
hw/axi_sram_rd.sv
hw/axi_sram_wr.sv
hw/axi_sram_top.sv
sim/tb_axi_sram.sv

// File: Bender.yml
package:
  name: axi_sram

sources:
  - files:
      - hw/axi_sram_pkg.sv
      - hw/axi_burst_addr.sv
      - hw/sram_mem.sv
      - hw/axi_sram_rd.sv
      - hw/axi_sram_wr.sv
      - hw/axi_sram_top.sv
  - target: simulation
    files:
      - sim/tb_axi_sram.sv
